// ==== logic/muldiv_pkg.sv ====
`default_nettype none

package muldiv_pkg;

    // architecture sizes
    localparam int XLEN      = 32;
    localparam int NUM_STEPS = 32;   // one result bit per step
    localparam int STEP_W    = 6;    // holds 0..NUM_STEPS

    // operations in RISC-V funct3 encoding, bit 2 marks the divide group
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_e;

endpackage

`default_nettype wire

// ==== logic/muldiv_ctl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// sequencing strobes from the controller to both datapaths
interface muldiv_ctl_if;

    logic load;     // one-cycle pulse, capture operands
    logic step;     // high during every iteration cycle
    logic finish;   // one-cycle pulse, register the result
    logic sel_div;  // current operation is DIV/DIVU/REM/REMU

    modport ctrl (
        output load,
        output step,
        output finish,
        output sel_div
    );

    modport dp (
        input load,
        input step,
        input finish,
        input sel_div
    );

endinterface

`default_nettype wire

// ==== logic/step_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_counter import muldiv_pkg::*; (
    input  wire logic I_clk,
    input  wire logic I_reset,
    input  wire logic count_start,
    input  wire logic count_en,
    output logic      count_last
);

    logic [STEP_W-1:0] count;  // steps done so far

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            count <= '0;
        end else if (count_start) begin
            count <= '0;
        end else if (count_en) begin
            count <= count + 1'b1;
        end
    end

    // high in the final step cycle only
    assign count_last = count_en && (count == STEP_W'(NUM_STEPS - 1));

    // the controller must stop stepping once the last step is flagged
    a_count_range: assert property (
        @(posedge I_clk) disable iff (I_reset) count <= STEP_W'(NUM_STEPS)
    );

endmodule

`default_nettype wire

// ==== logic/muldiv_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_ctrl import muldiv_pkg::*; (
    input  wire logic        I_clk,
    input  wire logic        I_reset,
    input  wire logic        I_en,
    input  wire muldiv_op_e  I_op,
    muldiv_ctl_if.ctrl       ctl,
    output logic             count_start,
    output logic             count_en,
    input  wire logic        count_last,
    output logic             O_busy
);

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_RUN    = 2'd1,
        ST_FINISH = 2'd2
    } state_e;

    state_e state;
    logic   sel_div_q;  // operation class held while busy
    logic   op_is_div;

    assign op_is_div = I_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            state     <= ST_IDLE;
            sel_div_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (I_en) begin
                        state     <= ST_RUN;
                        sel_div_q <= op_is_div;
                    end
                end
                ST_RUN: begin
                    if (count_last) state <= ST_FINISH;  // 32nd step done
                end
                ST_FINISH: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // a start is only taken while idle
    assign ctl.load   = (state == ST_IDLE) && I_en;
    assign ctl.step   = (state == ST_RUN);
    assign ctl.finish = (state == ST_FINISH);

    // while idle the select follows I_op so the load pulse reaches the right datapath
    assign ctl.sel_div = (state == ST_IDLE) ? op_is_div : sel_div_q;

    assign count_start = ctl.load;
    assign count_en    = ctl.step;
    assign O_busy      = (state != ST_IDLE);

    // the counter must end the run after NUM_STEPS steps
    a_run_length: assert property (
        @(posedge I_clk) disable iff (I_reset) ctl.step [* NUM_STEPS] |=> !ctl.step
    );

    // every load restarts the count so the first step is never the last
    a_fresh_count: assert property (
        @(posedge I_clk) disable iff (I_reset) ctl.load |=> !count_last
    );

endmodule

`default_nettype wire

// ==== logic/div_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

// restoring divider, one quotient bit per step
module div_datapath import muldiv_pkg::*; (
    input  wire logic         I_clk,
    input  wire logic         I_reset,
    muldiv_ctl_if.dp          ctl,
    input  wire muldiv_op_e   I_op,
    input  wire logic [XLEN-1:0] I_a,
    input  wire logic [XLEN-1:0] I_b,
    output logic [XLEN-1:0]   div_result
);

    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   quot_mask;  // bit being decided this step
    logic [XLEN-1:0]   dividend;   // becomes the remainder magnitude
    logic [2*XLEN-2:0] divisor;    // starts at bit XLEN-1 and walks down
    logic              want_quot;
    logic              neg_result;

    logic              is_signed;
    logic              is_div;
    logic              neg_a;
    logic              neg_b;
    logic [XLEN-1:0]   mag_a;
    logic [XLEN-1:0]   mag_b;
    logic [XLEN-1:0]   raw;

    assign is_signed = (I_op == OP_DIV) || (I_op == OP_REM);
    assign is_div    = (I_op == OP_DIV) || (I_op == OP_DIVU);
    assign neg_a     = is_signed && I_a[XLEN-1];
    assign neg_b     = is_signed && I_b[XLEN-1];
    assign mag_a     = neg_a ? -I_a : I_a;
    assign mag_b     = neg_b ? -I_b : I_b;

    assign raw = want_quot ? quotient : dividend;

    always_ff @(posedge I_clk) begin
        if (ctl.sel_div && ctl.load) begin
            quotient   <= '0;
            quot_mask  <= {1'b1, {(XLEN-1){1'b0}}};
            dividend   <= mag_a;
            divisor    <= {mag_b, {(XLEN-1){1'b0}}};
            want_quot  <= is_div;
            // a zero divisor must leave the all-ones quotient positive
            // remainder takes the sign of the dividend
            neg_result <= (is_div && is_signed && (I_a[XLEN-1] != I_b[XLEN-1]) && (I_b != '0))
                        || (!is_div && neg_a);
        end else if (ctl.sel_div && ctl.step) begin
            if (divisor <= {{(XLEN-1){1'b0}}, dividend}) begin
                dividend <= dividend - divisor[XLEN-1:0];  // upper bits are zero here
                quotient <= quotient | quot_mask;
            end
            divisor   <= divisor >> 1;
            quot_mask <= quot_mask >> 1;
        end
    end

    // sign-corrected write-back on finish
    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            div_result <= '0;
        end else if (ctl.sel_div && ctl.finish) begin
            div_result <= neg_result ? -raw : raw;
        end
    end

    // controller must not restart a division in the middle of its steps
    a_no_load_in_step: assert property (
        @(posedge I_clk) disable iff (I_reset) ctl.load |-> !ctl.step
    );

endmodule

`default_nettype wire

// ==== logic/mul_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

// shift-add multiplier, one multiplier bit per step
module mul_datapath import muldiv_pkg::*; (
    input  wire logic         I_clk,
    input  wire logic         I_reset,
    muldiv_ctl_if.dp          ctl,
    input  wire muldiv_op_e   I_op,
    input  wire logic [XLEN-1:0] I_a,
    input  wire logic [XLEN-1:0] I_b,
    output logic [XLEN-1:0]   mul_result
);

    logic [2*XLEN-1:0] multiplicand;  // shifted left each step
    logic [XLEN-1:0]   multiplier;    // shifted right each step
    logic [2*XLEN-1:0] acc;
    logic              neg_prod;
    logic              want_high;

    logic              a_signed;
    logic              b_signed;
    logic              neg_a;
    logic              neg_b;
    logic [XLEN-1:0]   mag_a;
    logic [XLEN-1:0]   mag_b;
    logic [2*XLEN-1:0] prod;

    // MULHSU treats only rs1 as signed and the MUL low word is sign agnostic
    assign a_signed = (I_op == OP_MULH) || (I_op == OP_MULHSU);
    assign b_signed = (I_op == OP_MULH);
    assign neg_a    = a_signed && I_a[XLEN-1];
    assign neg_b    = b_signed && I_b[XLEN-1];
    assign mag_a    = neg_a ? -I_a : I_a;
    assign mag_b    = neg_b ? -I_b : I_b;

    assign prod = neg_prod ? -acc : acc;

    always_ff @(posedge I_clk) begin
        if (!ctl.sel_div && ctl.load) begin
            multiplicand <= {{XLEN{1'b0}}, mag_a};
            multiplier   <= mag_b;
            acc          <= '0;
            neg_prod     <= neg_a ^ neg_b;
            want_high    <= (I_op != OP_MUL);
        end else if (!ctl.sel_div && ctl.step) begin
            if (multiplier[0]) acc <= acc + multiplicand;
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            mul_result <= '0;
        end else if (!ctl.sel_div && ctl.finish) begin
            mul_result <= want_high ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/muldiv_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit import muldiv_pkg::*; (
    input  wire logic            I_clk,
    input  wire logic            I_reset,
    input  wire logic            I_en,
    input  wire muldiv_op_e      I_op,
    input  wire logic [XLEN-1:0] I_a,
    input  wire logic [XLEN-1:0] I_b,
    output logic [XLEN-1:0]      O_result,
    output logic                 O_busy
);

    muldiv_ctl_if ctl ();

    logic            count_start;
    logic            count_en;
    logic            count_last;
    logic [XLEN-1:0] div_result;
    logic [XLEN-1:0] mul_result;
    logic            res_sel_div;  // which datapath wrote last

    muldiv_ctrl u_ctrl (
        .I_clk       (I_clk),
        .I_reset     (I_reset),
        .I_en        (I_en),
        .I_op        (I_op),
        .ctl         (ctl.ctrl),
        .count_start (count_start),
        .count_en    (count_en),
        .count_last  (count_last),
        .O_busy      (O_busy)
    );

    step_counter u_step_counter (
        .I_clk       (I_clk),
        .I_reset     (I_reset),
        .count_start (count_start),
        .count_en    (count_en),
        .count_last  (count_last)
    );

    div_datapath u_div (
        .I_clk      (I_clk),
        .I_reset    (I_reset),
        .ctl        (ctl.dp),
        .I_op       (I_op),
        .I_a        (I_a),
        .I_b        (I_b),
        .div_result (div_result)
    );

    mul_datapath u_mul (
        .I_clk      (I_clk),
        .I_reset    (I_reset),
        .ctl        (ctl.dp),
        .I_op       (I_op),
        .I_a        (I_a),
        .I_b        (I_b),
        .mul_result (mul_result)
    );

    // sel_div moves at the next load, so the output select only follows it on finish
    // and the old result stays visible while the next operation runs
    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            res_sel_div <= 1'b0;
        end else if (ctl.finish) begin
            res_sel_div <= ctl.sel_div;
        end
    end

    assign O_result = res_sel_div ? div_result : mul_result;

endmodule

`default_nettype wire

// ==== test/muldiv_ref.svh ====
`ifndef MULDIV_REF_SVH
`define MULDIV_REF_SVH

`default_nettype none

// expected result of one operation, worked out on 64-bit operands
function automatic logic [31:0] ref_muldiv(input muldiv_pkg::muldiv_op_e op,
                                           input logic [31:0] a,
                                           input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] ub_s;   // b zero extended, always positive
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        full;
    logic               ovf;    // most negative value over minus one
    sa   = {{32{a[31]}}, a};
    sb   = {{32{b[31]}}, b};
    ua   = {32'b0, a};
    ub   = {32'b0, b};
    ub_s = ub;
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    full = '0;
    case (op)
        muldiv_pkg::OP_MUL:    full = ua * ub;
        muldiv_pkg::OP_MULH:   full = sa * sb;
        muldiv_pkg::OP_MULHSU: full = sa * ub_s;
        muldiv_pkg::OP_MULHU:  full = ua * ub;
        muldiv_pkg::OP_DIV: begin
            if (b == '0)   full = '1;           // quotient of all ones
            else if (ovf)  full = {32'b0, a};
            else           full = sa / sb;      // truncates toward zero
        end
        muldiv_pkg::OP_DIVU: begin
            if (b == '0) full = '1;
            else         full = ua / ub;
        end
        muldiv_pkg::OP_REM: begin
            if (b == '0)   full = {32'b0, a};   // remainder is the dividend
            else if (ovf)  full = '0;
            else           full = sa % sb;      // sign follows the dividend
        end
        default: begin
            if (b == '0) full = {32'b0, a};
            else         full = ua % ub;
        end
    endcase
    if (op inside {muldiv_pkg::OP_MULH, muldiv_pkg::OP_MULHSU, muldiv_pkg::OP_MULHU})
        return full[63:32];
    return full[31:0];
endfunction

`default_nettype wire

`endif

// ==== test/muldiv_tb.sv ====
`timescale 1ns/1ps
`include "muldiv_ref.svh"
`default_nettype none

module muldiv_tb import muldiv_pkg::*;;

    logic            clk;
    logic            reset;
    logic            en;
    muldiv_op_e      op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] result;
    logic            busy;

    logic [XLEN-1:0] expected;     // result of the operation in flight
    logic [XLEN-1:0] prev_result;  // O_result one edge earlier
    logic [31:0]     rng;
    bit              started;      // first operation has been issued
    bit              timed_out;
    int              err_count;
    int              ops_done;
    int              tests_run;
    int              tests_failed;

    logic [XLEN-1:0] corner_vals [5] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000,
                                         32'hffff_ffff};

    muldiv_unit dut (
        .I_clk    (clk),
        .I_reset  (reset),
        .I_en     (en),
        .I_op     (op),
        .I_a      (a),
        .I_b      (b),
        .O_result (result),
        .O_busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always_ff @(posedge clk) prev_result <= result;

    a_reset_busy: assert property (@(posedge clk) disable iff (reset) !started |-> !busy)
        else begin
            err_count++;
            $display("O_busy went high after reset before any start");
        end

    a_reset_result: assert property (@(posedge clk) disable iff (reset)
        !started |-> result == '0)
        else begin
            err_count++;
            $display("Fail O_result after reset: got %h expected 00000000", $sampled(result));
        end

    // 32 steps and one finish cycle before idle again
    a_latency: assert property (@(posedge clk) disable iff (reset)
        (en && !busy) |=> busy [* NUM_STEPS + 1] ##1 !busy)
        else begin
            err_count++;
            $display("O_busy did not stay high for exactly %0d cycles after a start",
                     NUM_STEPS + 1);
        end

    a_result: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> result == expected)
        else begin
            err_count++;
            $display("Fail O_result: got %h expected %h", $sampled(result), $sampled(expected));
        end

    a_held: assert property (@(posedge clk) disable iff (reset)
        !$fell(busy) |-> result == prev_result)
        else begin
            err_count++;
            $display("Fail O_result while held: got %h expected %h",
                     $sampled(result), $sampled(prev_result));
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;  // inputs change well clear of the edge
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (busy && !timed_out) begin
            next_cycle();
            waited++;
            if (waited > 100) begin
                timed_out = 1'b1;
                $display("timeout: O_busy still high after %0d cycles", waited);
            end
        end
    endtask

    task automatic start_op(input muldiv_op_e op_i, input logic [XLEN-1:0] a_i,
                            input logic [XLEN-1:0] b_i);
        wait_idle();
        if (timed_out) return;
        en       = 1'b1;
        op       = op_i;
        a        = a_i;
        b        = b_i;
        started  = 1'b1;
        ops_done++;
        next_cycle();  // accepted at this edge
        en       = 1'b0;
        // the previous result is checked at the acceptance edge
        expected = ref_muldiv(op_i, a_i, b_i);
    endtask

    task automatic run_op(input muldiv_op_e op_i, input logic [XLEN-1:0] a_i,
                          input logic [XLEN-1:0] b_i);
        start_op(op_i, a_i, b_i);
        wait_idle();
    endtask

    // second start lands mid-run and once more in the finish cycle
    task automatic strobe_during_op(input muldiv_op_e op_i, input logic [XLEN-1:0] a_i,
                                    input logic [XLEN-1:0] b_i, input muldiv_op_e other);
        start_op(op_i, a_i, b_i);
        en = 1'b1;
        op = other;
        a  = ~a_i;
        b  = b_i + 1;
        next_cycle();
        en = 1'b0;
        repeat (NUM_STEPS - 1) next_cycle();
        en = 1'b1;
        a  = 32'h0bad_f00d;
        next_cycle();
        en = 1'b0;
        wait_idle();
    endtask

    task automatic report_test(input string name, input int errs_before, input int ops_before);
        tests_run++;
        if (err_count != errs_before || timed_out) tests_failed++;
        $display("%-16s %4d operations, %0d errors", name, ops_done - ops_before,
                 err_count - errs_before);
    endtask

    initial begin
        int e0;
        int o0;
        reset        = 1'b1;
        en           = 1'b0;
        op           = OP_MUL;
        a            = '0;
        b            = '0;
        expected     = '0;
        rng          = 32'd26;
        started      = 1'b0;
        timed_out    = 1'b0;
        err_count    = 0;
        ops_done     = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b0;

        e0 = err_count;
        o0 = ops_done;
        repeat (6) next_cycle();
        report_test("reset_state", e0, o0);

        e0 = err_count;
        o0 = ops_done;
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 8; k++) begin
                logic [XLEN-1:0] ra;
                logic [XLEN-1:0] rb;
                rng = xorshift32(rng);
                ra  = rng;
                rng = xorshift32(rng);
                rb  = (i % 2) ? rng >> rng[4:0] : rng;  // smaller divisors now and then
                run_op(muldiv_op_e'(k), ra, rb);
            end
        end
        report_test("random", e0, o0);

        e0 = err_count;
        o0 = ops_done;
        foreach (corner_vals[i]) begin
            for (int k = 4; k < 8; k++) run_op(muldiv_op_e'(k), corner_vals[i], '0);
        end
        for (int k = 4; k < 8; k++) run_op(muldiv_op_e'(k), 32'h8000_0000, 32'hffff_ffff);
        foreach (corner_vals[i]) begin
            foreach (corner_vals[j]) begin
                for (int k = 0; k < 4; k++) begin
                    run_op(muldiv_op_e'(k), corner_vals[i], corner_vals[j]);
                end
            end
        end
        report_test("corners", e0, o0);

        e0 = err_count;
        o0 = ops_done;
        strobe_during_op(OP_DIV, 32'hdead_beef, 32'h0000_1234, OP_MULHU);
        strobe_during_op(OP_MULH, 32'h8765_4321, 32'h1357_9bdf, OP_REMU);
        report_test("ignored_strobe", e0, o0);

        e0 = err_count;
        o0 = ops_done;
        run_op(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff);
        repeat (12) next_cycle();
        run_op(OP_REMU, 32'd100, 32'd7);
        repeat (12) next_cycle();
        report_test("held_result", e0, o0);

        $display("tests %0d, failed tests %0d, operations %0d, errors %0d",
                 tests_run, tests_failed, ops_done, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+test
logic/muldiv_pkg.sv
logic/muldiv_ctl_if.sv
logic/step_counter.sv
logic/muldiv_ctrl.sv
logic/div_datapath.sv
logic/mul_datapath.sv
logic/muldiv_unit.sv
test/muldiv_tb.sv
